//--- bench/nic_tests.mem
// kind addr data expect, hex; 1 write, 2 read, 3 traffic (addr mask, data cycles),
// 4 config field check, 5 health (data levels), 6 align to rate window, 0 end
2 0000 0000000000000000 1000010000000000
2 0002 0000000000000000 a1c80e93d25b64f7
2 0004 0000000000000000 3a5c9e017b244f6d
5 0000 000000000000000c 0000000000000000
2 0020 0000000000000000 0000000000000030
1 0010 00000123456789c0 0000000000000000
4 0010 0000000000000000 00000123456789c0
1 0012 000002abcdef0140 0000000000000000
4 0012 0000000000000000 000002abcdef0140
1 0014 0000000000000001 0000000000000000
4 0014 0000000000000000 0000000000000001
1 0016 0000000000000004 0000000000000000
4 0016 0000000000000000 0000000000000003
1 0018 0000000000000001 0000000000000000
4 0018 0000000000000000 0000000000000001
4 0018 0000000000000000 0000000000000000
1 001a 0000000000000001 0000000000000000
4 001a 0000000000000000 0000000000000001
1 001c ffff0a1b2c3d4e5f 0000000000000000
4 001c 0000000000000000 00000a1b2c3d4e5f
1 001e ffff0000c0a80105 0000000000000000
4 001e 0000000000000000 00000000c0a80105
2 0010 0000000000000000 00000123456789c0
2 0012 0000000000000000 000002abcdef0140
2 0014 0000000000000000 0000000000000001
2 0016 0000000000000000 0000000000000004
2 001a 0000000000000000 0000000000000001
2 001c 0000000000000000 00000a1b2c3d4e5f
2 001e 0000000000000000 00000000c0a80105
2 0018 0000000000000000 0000000000000000
2 0006 0000000000000000 0000000000000000
2 0020 0000000000000000 0000000000000038
5 0000 0000000000000004 0000000000000000
2 0020 0000000000000000 0000000000000020
5 0000 000000000000000e 0000000000000000
2 0020 0000000000000000 000000000000003d
5 0000 0000000000000001 0000000000000000
2 0020 0000000000000000 0000000000000023
3 001f 0000000000000001 0000000000000000
3 001e 0000000000000001 0000000000000000
3 001c 0000000000000001 0000000000000000
3 0018 0000000000000001 0000000000000000
3 0010 0000000000000001 0000000000000000
1 0024 0000000000000000 0000000000000000
2 0026 0000000000000000 0000000000000005
1 0024 0000000000000001 0000000000000000
2 0026 0000000000000000 0000000000000004
1 0024 0000000000000002 0000000000000000
2 0026 0000000000000000 0000000000000003
1 0024 0000000000000003 0000000000000000
2 0026 0000000000000000 0000000000000002
1 0024 0000000000000004 0000000000000000
2 0026 0000000000000000 0000000000000001
1 0024 0000000000000005 0000000000000000
2 0026 0000000000000000 0000000000000000
1 0024 0000000000000006 0000000000000000
2 0026 0000000000000000 0000000000000000
1 0024 0000000000000007 0000000000000000
2 0026 0000000000000000 0000000000000000
6 0000 0000000000000000 0000000000000000
3 0010 0000000000000080 0000000000000000
2 0022 0000000000000000 0000000000000040
0 0000 0000000000000000 0000000000000000

//--- flist.f
hdl/nic_pkg.sv
hdl/nic_csr_regs.sv
hdl/nic_traffic_monitor.sv
hdl/nic_csr_read.sv
hdl/nic_top.sv
bench/nic_properties.sv
bench/nic_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the NIC testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module nic_tb -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vnic_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
    exit 0
fi
exit 1

//--- bench/nic_tb.sv
/*
  Testbench for nic_top, stepped line by line through bench/nic_tests.mem.
  Run from the project root so that the data file path resolves.
  Each line takes one ccip_clk cycle, except align lines, which may take none.
  Inputs change on the falling edge and outputs are sampled there too.
*/

`timescale 1ns/1ns

module nic_tb import nic_pkg::*; ();

    localparam int MAX_LINES      = 256;
    localparam int TIMEOUT_MARGIN = 100;

    // Line kinds of the data file
    localparam logic [3:0] K_WRITE   = 4'd1;
    localparam logic [3:0] K_READ    = 4'd2;
    localparam logic [3:0] K_TRAFFIC = 4'd3;
    localparam logic [3:0] K_CFG     = 4'd4;
    localparam logic [3:0] K_HEALTH  = 4'd5;
    localparam logic [3:0] K_ALIGN   = 4'd6;

    logic          ccip_clk;
    logic          reset;
    nic_mmio_req_t mmio_req;
    nic_traffic_t  traffic;
    nic_health_t   health;
    nic_mmio_rsp_t mmio_rsp;
    nic_config_t   cfg;

    // Four words per line: kind, address, data, expected
    logic [63:0] test_words [0:4*MAX_LINES-1];

    nic_config_t exp_cfg;
    int          error_count;
    int          check_count;
    int          num_lines;
    int          cycle_limit        = 0;
    int          cycle_total        = 0;
    int          cycles_since_reset = 0;

    nic_top UUT (
        .ccip_clk (ccip_clk),
        .reset    (reset),
        .mmio_req (mmio_req),
        .traffic  (traffic),
        .health   (health),
        .mmio_rsp (mmio_rsp),
        .cfg      (cfg)
    );

    always #20 ccip_clk = ~ccip_clk;

    // ==============================
    // Cycle counting and timeout
    // ==============================
    always @(posedge ccip_clk) begin
        cycle_total <= cycle_total + 1;
        // Same count as the DUT rate window, zero on the first cycle after reset
        if (reset) begin
            cycles_since_reset <= 0;
        end else begin
            cycles_since_reset <= cycles_since_reset + 1;
        end
        if (cycle_limit > 0 && cycle_total >= cycle_limit) begin
            $display("Timeout after %0d cycles, the test lines did not finish", cycle_total);
            $display("Regression failed");
            $finish;
        end
    end

    // ==============================
    // Compare tasks
    // ==============================
    task automatic check_data(input string name, input nic_mmio_data_t got,
                              input nic_mmio_data_t exp);
        check_count++;
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp.raw, got.raw);
            error_count++;
        end
    endtask

    task automatic check_tid(input string name, input mmio_tid_t got, input mmio_tid_t exp);
        check_count++;
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, got);
            error_count++;
        end
    endtask

    task automatic check_config(input string name, input nic_config_t got,
                                input nic_config_t exp);
        check_count++;
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, got);
            error_count++;
        end
    endtask

    // ==============================
    // Line actions
    // ==============================
    task automatic write_csr(input mmio_addr_t addr, input logic [63:0] data);
        mmio_req.wr_valid = 1'b1;
        mmio_req.address  = addr;
        mmio_req.data.raw = data;
        @(negedge ccip_clk);
        mmio_req = '0;
    endtask

    task automatic read_csr(input mmio_addr_t addr, input mmio_tid_t tid,
                            input logic [63:0] expect_word);
        nic_mmio_data_t exp_data;
        exp_data.raw      = expect_word;
        mmio_req.rd_valid = 1'b1;
        mmio_req.tid      = tid;
        mmio_req.address  = addr;
        @(negedge ccip_clk);
        mmio_req = '0;
        if (mmio_rsp.rd_valid !== 1'b1) begin
            $display("Read of address %0d with tid %0d got no response in the next cycle",
                     addr, tid);
            error_count++;
        end else begin
            check_tid("mmio_rsp.tid", mmio_rsp.tid, tid);
            check_data("mmio_rsp.data", mmio_rsp.data, exp_data);
        end
    endtask

    task automatic run_traffic(input nic_traffic_t mask, input int cycles);
        traffic = mask;
        repeat (cycles) @(negedge ccip_clk);
        traffic = '0;
    endtask

    // Expected field values are the stored ones, so num_flows is already minus one
    task automatic expect_config(input mmio_addr_t addr, input logic [63:0] value);
        exp_cfg.init = 1'b0;
        case (addr)
            ADDR_MEM_TX:    exp_cfg.mem_tx_addr  = cl_addr_t'(value);
            ADDR_MEM_RX:    exp_cfg.mem_rx_addr  = cl_addr_t'(value);
            ADDR_START:     exp_cfg.start        = value[0];
            ADDR_NUM_FLOWS: exp_cfg.num_flows_m1 = value[LMAX_NUM_OF_FLOWS-1:0];
            ADDR_INIT:      exp_cfg.init         = value[0];
            ADDR_LB:        exp_cfg.lb           = value[0];
            ADDR_PHY_ADDR:  exp_cfg.phy_addr     = value[47:0];
            ADDR_IPV4_ADDR: exp_cfg.ipv4_addr    = value[31:0];
            default: begin
                $display("Config line names no config field at address %0d", addr);
                error_count++;
            end
        endcase
        check_config("cfg", cfg, exp_cfg);
        @(negedge ccip_clk);
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        logic [3:0]  kind;
        logic [63:0] data;
        logic [63:0] expect_word;
        mmio_addr_t  addr;
        int          traffic_cycles;
        int          align_lines;

        ccip_clk       = 1'b0;
        reset          = 1'b1;
        mmio_req       = '0;
        traffic        = '0;
        health         = '0;
        exp_cfg        = '0;
        error_count    = 0;
        check_count    = 0;
        num_lines      = 0;
        traffic_cycles = 0;
        align_lines    = 0;

        $readmemh("bench/nic_tests.mem", test_words);
        while (num_lines < MAX_LINES && test_words[4*num_lines] != 64'd0) begin
            if (test_words[4*num_lines][3:0] == K_TRAFFIC) begin
                traffic_cycles += int'(test_words[4*num_lines+2]);
            end
            if (test_words[4*num_lines][3:0] == K_ALIGN) begin
                align_lines++;
            end
            num_lines++;
        end
        if (num_lines == 0) begin
            $display("No test lines could be read from bench/nic_tests.mem");
            error_count++;
        end
        cycle_limit = 3 + 2 * num_lines + traffic_cycles
                      + align_lines * RATE_WINDOW_CYCLES + TIMEOUT_MARGIN;

        repeat (3) @(negedge ccip_clk);
        reset = 1'b0;

        for (int idx = 0; idx < num_lines; idx++) begin
            kind        = test_words[4*idx][3:0];
            addr        = mmio_addr_t'(test_words[4*idx+1]);
            data        = test_words[4*idx+2];
            expect_word = test_words[4*idx+3];
            case (kind)
                K_WRITE:   write_csr(addr, data);
                K_READ:    read_csr(addr, mmio_tid_t'(idx), expect_word);
                K_TRAFFIC: run_traffic(nic_traffic_t'(addr[4:0]), int'(data));
                K_CFG:     expect_config(addr, expect_word);
                K_HEALTH: begin
                    health = nic_health_t'(data[3:0]);
                    @(negedge ccip_clk);
                end
                K_ALIGN: begin
                    // Next rising edge starts a rate window
                    while (cycles_since_reset % RATE_WINDOW_CYCLES != 0) begin
                        @(negedge ccip_clk);
                    end
                end
                default: begin
                    $display("Test line %0d has an unknown kind %0d", idx, kind);
                    error_count++;
                end
            endcase
        end

        @(negedge ccip_clk);
        error_count += UUT.u_properties.fail_count;
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- bench/nic_properties.sv
/*
  Concurrent checks on the MMIO read response and the init strobe.
  Bound into nic_top, so they watch every instance of the core.
*/

`timescale 1ns/1ns

module nic_properties import nic_pkg::*; (
    input logic          ccip_clk,
    input logic          reset,
    input nic_mmio_req_t mmio_req,
    input nic_mmio_rsp_t mmio_rsp,
    input nic_config_t   cfg
);

    // Number of failed assertions
    int fail_count = 0;

    // ==============================
    // Read response timing
    // ==============================
    a_rd_follows: assert property (@(posedge ccip_clk) disable iff (reset)
        mmio_req.rd_valid |=> mmio_rsp.rd_valid)
        else begin
            $error("rd_valid missing one cycle after a read request");
            fail_count++;
        end

    a_rd_no_spurious: assert property (@(posedge ccip_clk) disable iff (reset)
        !mmio_req.rd_valid |=> !mmio_rsp.rd_valid)
        else begin
            $error("rd_valid raised without a read request");
            fail_count++;
        end

    a_tid_echo: assert property (@(posedge ccip_clk) disable iff (reset)
        mmio_req.rd_valid |=> (mmio_rsp.tid == $past(mmio_req.tid)))
        else begin
            $error("Response tid differs from the request tid");
            fail_count++;
        end

    // Init is a single-cycle strobe
    a_init_pulse: assert property (@(posedge ccip_clk) disable iff (reset)
        cfg.init |=> !cfg.init)
        else begin
            $error("cfg.init held for two cycles");
            fail_count++;
        end

    a_reset_quiet: assert property (@(posedge ccip_clk)
        reset |=> (!mmio_rsp.rd_valid && !cfg.init))
        else begin
            $error("rd_valid or init high during reset");
            fail_count++;
        end

endmodule

bind nic_top nic_properties u_properties (
    .ccip_clk (ccip_clk),
    .reset    (reset),
    .mmio_req (mmio_req),
    .mmio_rsp (mmio_rsp),
    .cfg      (cfg)
);

//--- hdl/nic_top.sv
/*
  NIC control and monitoring core, single ccip_clk domain.
  Transport and network layers live outside and only show up as
  traffic strobes and health levels. No back-pressure on MMIO.
  Read latency is one cycle; a write is readable two cycles later.
*/

`timescale 1ns/1ns

module nic_top import nic_pkg::*; (
    input  logic          ccip_clk,
    input  logic          reset,
    input  nic_mmio_req_t mmio_req,
    input  nic_traffic_t  traffic,
    input  nic_health_t   health,
    output nic_mmio_rsp_t mmio_rsp,
    output nic_config_t   cfg
);

    logic [2:0]  pck_sel;
    logic [31:0] rps;
    pkt_count_t  pck_cnt;

    // ==============================
    // Configuration registers
    // ==============================
    nic_csr_regs u_csr_regs (
        .ccip_clk (ccip_clk),
        .reset    (reset),
        .mmio_req (mmio_req),
        .cfg      (cfg),
        .pck_sel  (pck_sel)
    );

    // ==============================
    // Traffic monitoring
    // ==============================
    nic_traffic_monitor u_traffic_monitor (
        .ccip_clk (ccip_clk),
        .reset    (reset),
        .traffic  (traffic),
        .pck_sel  (pck_sel),
        .rps      (rps),
        .pck_cnt  (pck_cnt)
    );

    // Read path sees config, health and both monitor results
    nic_csr_read u_csr_read (
        .ccip_clk (ccip_clk),
        .reset    (reset),
        .mmio_req (mmio_req),
        .cfg      (cfg),
        .health   (health),
        .rps      (rps),
        .pck_cnt  (pck_cnt),
        .mmio_rsp (mmio_rsp)
    );

endmodule

//--- hdl/nic_csr_read.sv
/*
  NIC status register and the MMIO read response path.
  Every read is answered exactly one cycle later with its tid echoed.
  Unmapped and write-only addresses return zero.
*/

`timescale 1ns/1ns

module nic_csr_read import nic_pkg::*; (
    input  logic          ccip_clk,
    input  logic          reset,
    input  nic_mmio_req_t mmio_req,
    input  nic_config_t   cfg,
    input  nic_health_t   health,
    input  logic [31:0]   rps,
    input  pkt_count_t    pck_cnt,
    output nic_mmio_rsp_t mmio_rsp
);

    nic_status_t    status_q;
    logic           ready;
    nic_mmio_data_t rd_data;

    logic           rsp_valid_q;
    mmio_tid_t      rsp_tid_q;
    nic_mmio_data_t rsp_data_q;

    // ==============================
    // Status register
    // ==============================
    assign ready = health.ccip_ready & health.rpc_ready;

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            status_q        <= '0;
            status_q.nic_id <= NIC_ID;
        end else begin
            status_q.nic_id   <= NIC_ID;
            status_q.ready    <= ready;
            status_q.running  <= ready & cfg.start;
            status_q.err_ccip <= health.err_ccip;
            status_q.err_rpc  <= health.err_rpc;
            status_q.error    <= health.err_ccip | health.err_rpc;
        end
    end

    // ==============================
    // Read data decode
    // ==============================
    always_comb begin
        rd_data.raw = 64'd0;
        case (mmio_req.address)
            ADDR_DFH: begin
                // AFU feature type, last entry of the list
                rd_data.raw[63:60] = 4'h1;
                rd_data.raw[40]    = 1'b1;
            end
            ADDR_AFU_ID_L:  rd_data.raw = AFU_UUID[63:0];
            ADDR_AFU_ID_H:  rd_data.raw = AFU_UUID[127:64];
            ADDR_MEM_TX:    rd_data.raw = 64'(cfg.mem_tx_addr);
            ADDR_MEM_RX:    rd_data.raw = 64'(cfg.mem_rx_addr);
            ADDR_START:     rd_data.raw = 64'(cfg.start);
            ADDR_NUM_FLOWS: rd_data.raw = 64'(cfg.num_flows_m1) + 64'd1;
            ADDR_LB:        rd_data.raw = 64'(cfg.lb);
            ADDR_PHY_ADDR:  rd_data.net.phy_addr = cfg.phy_addr;
            ADDR_IPV4_ADDR: rd_data.raw = 64'(cfg.ipv4_addr);
            ADDR_STATUS:    rd_data.raw = 64'(status_q);
            ADDR_RPS:       rd_data.raw = 64'(rps);
            ADDR_PCK_CNT:   rd_data.raw = pck_cnt;
            default:        rd_data.raw = 64'd0;
        endcase
    end

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= mmio_req.rd_valid;
        end
    end

    always_ff @(posedge ccip_clk) begin
        rsp_tid_q  <= mmio_req.tid;
        rsp_data_q <= rd_data;
    end

    assign mmio_rsp.rd_valid = rsp_valid_q;
    assign mmio_rsp.tid      = rsp_tid_q;
    assign mmio_rsp.data     = rsp_data_q;

endmodule

//--- hdl/nic_traffic_monitor.sv
/*
  Request-rate window and packet event counters.
  Windows start on the first cycle after reset is released.
  Counter index: 0 rpc_in, 1 rpc_out, 2 pdrop_tx, 3 net_tx, 4 net_rx.
  Indices past the last counter read as zero.
*/

`timescale 1ns/1ns

module nic_traffic_monitor import nic_pkg::*; (
    input  logic         ccip_clk,
    input  logic         reset,
    input  nic_traffic_t traffic,
    input  logic [2:0]   pck_sel,
    output logic [31:0]  rps,
    output pkt_count_t   pck_cnt
);

    logic [$clog2(RATE_WINDOW_CYCLES)-1:0] win_cnt;
    logic                                  win_end;
    logic [31:0]                           rate_cnt;
    logic [31:0]                           rps_q;

    logic [NUM_PKT_COUNTERS-1:0] evt;
    pkt_count_t                  cnt [NUM_PKT_COUNTERS];

    // ==============================
    // Rate window
    // ==============================
    assign win_end = (win_cnt == $bits(win_cnt)'(RATE_WINDOW_CYCLES - 1));

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            win_cnt  <= '0;
            rate_cnt <= 32'd0;
            rps_q    <= 32'd0;
        end else begin
            if (win_end) begin
                // Last cycle of the window still counts
                rps_q    <= rate_cnt + 32'(traffic.rpc_in);
                rate_cnt <= 32'd0;
                win_cnt  <= '0;
            end else begin
                rate_cnt <= rate_cnt + 32'(traffic.rpc_in);
                win_cnt  <= win_cnt + 1'b1;
            end
        end
    end

    assign rps = rps_q;

    // ==============================
    // Packet counters
    // ==============================
    // Map strobes onto counter indices
    assign evt[0] = traffic.rpc_in;
    assign evt[1] = traffic.rpc_out;
    assign evt[2] = traffic.pdrop_tx;
    assign evt[3] = traffic.net_tx;
    assign evt[4] = traffic.net_rx;

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_PKT_COUNTERS; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_PKT_COUNTERS; i++) begin
                cnt[i] <= cnt[i] + pkt_count_t'(evt[i]);
            end
        end
    end

    // Selected counter, no register on the way out
    always_comb begin
        pck_cnt = '0;
        for (int i = 0; i < NUM_PKT_COUNTERS; i++) begin
            if (int'(pck_sel) == i) begin
                pck_cnt = cnt[i];
            end
        end
    end

endmodule

//--- hdl/nic_csr_regs.sv
/*
  MMIO write decode and the host-visible configuration registers.
  Writes are always accepted; a written value shows on cfg one cycle later.
  The flow count is kept minus one, so a write of 0 wraps to the maximum.
  cfg.init is a single-cycle strobe per write to ADDR_INIT.
*/

`timescale 1ns/1ns

module nic_csr_regs import nic_pkg::*; (
    input  logic          ccip_clk,
    input  logic          reset,
    input  nic_mmio_req_t mmio_req,
    output nic_config_t   cfg,
    output logic [2:0]    pck_sel
);

    nic_config_t cfg_q;
    logic [2:0]  pck_sel_q;

    // Per-register write enables
    logic wr_mem_tx;
    logic wr_mem_rx;
    logic wr_start;
    logic wr_num_flows;
    logic wr_init;
    logic wr_lb;
    logic wr_phy;
    logic wr_ipv4;
    logic wr_pck_sel;

    // ==============================
    // Write address decode
    // ==============================
    assign wr_mem_tx    = mmio_req.wr_valid && (mmio_req.address == ADDR_MEM_TX);
    assign wr_mem_rx    = mmio_req.wr_valid && (mmio_req.address == ADDR_MEM_RX);
    assign wr_start     = mmio_req.wr_valid && (mmio_req.address == ADDR_START);
    assign wr_num_flows = mmio_req.wr_valid && (mmio_req.address == ADDR_NUM_FLOWS);
    assign wr_init      = mmio_req.wr_valid && (mmio_req.address == ADDR_INIT);
    assign wr_lb        = mmio_req.wr_valid && (mmio_req.address == ADDR_LB);
    assign wr_phy       = mmio_req.wr_valid && (mmio_req.address == ADDR_PHY_ADDR);
    assign wr_ipv4      = mmio_req.wr_valid && (mmio_req.address == ADDR_IPV4_ADDR);
    assign wr_pck_sel   = mmio_req.wr_valid && (mmio_req.address == ADDR_PCK_SEL);

    // ==============================
    // Configuration registers
    // ==============================
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            cfg_q     <= '0;
            pck_sel_q <= 3'd0;
        end else begin
            // Init only lives for the cycle after its write
            cfg_q.init <= wr_init;

            if (wr_mem_tx) begin
                cfg_q.mem_tx_addr <= cl_addr_t'(mmio_req.data.raw);
            end

            if (wr_mem_rx) begin
                cfg_q.mem_rx_addr <= cl_addr_t'(mmio_req.data.raw);
            end

            if (wr_start) begin
                cfg_q.start <= mmio_req.data.raw[0];
            end

            if (wr_num_flows) begin
                cfg_q.num_flows_m1 <= mmio_req.data.raw[LMAX_NUM_OF_FLOWS-1:0] - 1'b1;
            end

            if (wr_lb) begin
                cfg_q.lb <= mmio_req.data.raw[0];
            end

            // Network addresses come through the net view of the word
            if (wr_phy) begin
                cfg_q.phy_addr <= mmio_req.data.net.phy_addr;
            end

            if (wr_ipv4) begin
                cfg_q.ipv4_addr <= mmio_req.data.net.phy_addr[31:0];
            end

            if (wr_pck_sel) begin
                pck_sel_q <= mmio_req.data.raw[2:0];
            end
        end
    end

    assign cfg     = cfg_q;
    assign pck_sel = pck_sel_q;

endmodule

//--- hdl/nic_pkg.sv
/*
  Shared constants, address map and types of the NIC control core.
  RATE_WINDOW_CYCLES is sized for simulation, not for a 1 s window.
  MMIO addresses are 32-bit word offsets, so 64-bit CSRs sit on even ones.
*/

package nic_pkg;

    // ==============================
    // Widths and constants
    // ==============================
    localparam int MMIO_ADDR_W        = 16;
    localparam int CL_ADDR_W          = 42;
    localparam int LMAX_NUM_OF_FLOWS  = 3;
    localparam int RATE_WINDOW_CYCLES = 64;
    localparam int NUM_PKT_COUNTERS   = 5;

    localparam logic [7:0]   NIC_ID   = 8'h01;
    localparam logic [127:0] AFU_UUID = 128'h3a5c_9e01_7b24_4f6d_a1c8_0e93_d25b_64f7;

    // ==============================
    // Basic types
    // ==============================
    typedef logic [MMIO_ADDR_W-1:0] mmio_addr_t;
    typedef logic [8:0]             mmio_tid_t;
    typedef logic [CL_ADDR_W-1:0]   cl_addr_t;
    typedef logic [63:0]            pkt_count_t;

    // Network view of an MMIO word; IPv4 sits in phy_addr[31:0]
    typedef struct packed {
        logic [15:0] rsvd;
        logic [47:0] phy_addr;
    } nic_net_addr_t;

    typedef union packed {
        logic [63:0]   raw;
        nic_net_addr_t net;
    } nic_mmio_data_t;

    typedef struct packed {
        logic           rd_valid;
        logic           wr_valid;
        mmio_tid_t      tid;
        mmio_addr_t     address;
        nic_mmio_data_t data;
    } nic_mmio_req_t;

    typedef struct packed {
        logic           rd_valid;
        mmio_tid_t      tid;
        nic_mmio_data_t data;
    } nic_mmio_rsp_t;

    typedef struct packed {
        cl_addr_t                     mem_tx_addr;
        cl_addr_t                     mem_rx_addr;
        logic                         start;
        logic [LMAX_NUM_OF_FLOWS-1:0] num_flows_m1;
        logic                         init;
        logic                         lb;
        logic [47:0]                  phy_addr;
        logic [31:0]                  ipv4_addr;
    } nic_config_t;

    // Single-cycle event strobes from the transport and network layers
    typedef struct packed {
        logic rpc_in;
        logic rpc_out;
        logic pdrop_tx;
        logic net_tx;
        logic net_rx;
    } nic_traffic_t;

    typedef struct packed {
        logic ccip_ready;
        logic rpc_ready;
        logic err_ccip;
        logic err_rpc;
    } nic_health_t;

    typedef struct packed {
        logic [7:0] nic_id;
        logic       ready;
        logic       running;
        logic       err_ccip;
        logic       err_rpc;
        logic       error;
    } nic_status_t;

    // ==============================
    // MMIO address map
    // ==============================
    localparam mmio_addr_t ADDR_DFH       = 16'd0;
    localparam mmio_addr_t ADDR_AFU_ID_L  = 16'd2;
    localparam mmio_addr_t ADDR_AFU_ID_H  = 16'd4;
    localparam mmio_addr_t ADDR_MEM_TX    = 16'd16;
    localparam mmio_addr_t ADDR_MEM_RX    = 16'd18;
    localparam mmio_addr_t ADDR_START     = 16'd20;
    localparam mmio_addr_t ADDR_NUM_FLOWS = 16'd22;
    localparam mmio_addr_t ADDR_INIT      = 16'd24;
    localparam mmio_addr_t ADDR_LB        = 16'd26;
    localparam mmio_addr_t ADDR_PHY_ADDR  = 16'd28;
    localparam mmio_addr_t ADDR_IPV4_ADDR = 16'd30;
    localparam mmio_addr_t ADDR_STATUS    = 16'd32;
    localparam mmio_addr_t ADDR_RPS       = 16'd34;
    localparam mmio_addr_t ADDR_PCK_SEL   = 16'd36;
    localparam mmio_addr_t ADDR_PCK_CNT   = 16'd38;

endpackage
